// File: source/i2c_bus_pkg.sv
`default_nettype none

package i2c_bus_pkg;

    //////////////////////////////
    // Bus protocol constants
    //////////////////////////////

    // Upper nibble of a control byte that addresses this slave.
    localparam logic [3:0] device_code = 4'b1010;

    // Data bits per byte on the bus.
    localparam int byte_bits = 8;

    //////////////////////////////
    // Bus conditions
    //////////////////////////////

    // Condition seen on one cycle. A start or stop lasts exactly one cycle.
    typedef enum logic [1:0] {
        cond_none  = 2'b00,
        cond_start = 2'b01,
        cond_stop  = 2'b10
    } bus_cond_e;

endpackage

`default_nettype wire

// File: source/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    //////////////////////////////
    // Memory geometry
    //////////////////////////////

    // Three block bits above the eight bit word address.
    localparam int mem_addr_bits = 11;
    localparam int mem_depth     = 2048;

    //////////////////////////////
    // Controller types
    //////////////////////////////

    typedef enum logic [3:0] {
        idle      = 4'd0,
        ctrl_rx   = 4'd1,
        ctrl_ack  = 4'd2,
        addr_rx   = 4'd3,
        addr_ack  = 4'd4,
        write_rx  = 4'd5,
        write_ack = 4'd6,
        read_tx   = 4'd7,
        read_ack  = 4'd8
    } slave_state_e;

    // Taken from bit 0 of the control byte.
    typedef enum logic {
        op_write = 1'b0,
        op_read  = 1'b1
    } access_op_e;

endpackage

`default_nettype wire

// File: source/i2c_line_sync.sv
`default_nettype none

module i2c_line_sync
    import i2c_bus_pkg::*;
(
    input  wire       sda,
    input  wire       rst_n,
    input  wire       bus_scl,
    input  wire       bus_data,
    output logic      scl_rise,
    output logic      scl_fall,
    output bus_cond_e bus_cond,
    output logic      data_bit
);

    logic scl_meta;
    logic scl_sync;
    logic scl_prev;
    logic data_meta;
    logic data_sync;
    logic data_prev;

    // Two flop synchronizers plus the previous level. All reset to the idle high level.
    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
        begin
            scl_meta  <= 1'b1;
            scl_sync  <= 1'b1;
            scl_prev  <= 1'b1;
            data_meta <= 1'b1;
            data_sync <= 1'b1;
            data_prev <= 1'b1;
        end
        else
        begin
            scl_meta  <= bus_scl;
            scl_sync  <= scl_meta;
            scl_prev  <= scl_sync;
            data_meta <= bus_data;
            data_sync <= data_meta;
            data_prev <= data_sync;
        end
    end

    //////////////////////////////
    // Edge and condition register
    //////////////////////////////

    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
        begin
            scl_rise <= 1'b0;
            scl_fall <= 1'b0;
            bus_cond <= cond_none;
            data_bit <= 1'b1;
        end
        else
        begin
            scl_rise <= scl_sync & ~scl_prev;
            scl_fall <= ~scl_sync & scl_prev;
            data_bit <= data_sync;
            // A data edge with the clock held high is a bus condition.
            if (scl_sync && scl_prev && data_prev && !data_sync)
                bus_cond <= cond_start;
            else if (scl_sync && scl_prev && !data_prev && data_sync)
                bus_cond <= cond_stop;
            else
                bus_cond <= cond_none;
        end
    end

endmodule

`default_nettype wire

// File: source/eeprom_slave_fsm.sv
`default_nettype none

module eeprom_slave_fsm
    import i2c_bus_pkg::*;
    import eeprom_pkg::*;
(
    input  wire                      sda,
    input  wire                      rst_n,
    input  wire                      scl_rise,
    input  wire                      scl_fall,
    input  var bus_cond_e            bus_cond,
    input  wire                      data_bit,
    output logic                     data_pull_low,
    output logic                     mem_write,
    output logic [mem_addr_bits-1:0] mem_waddr,
    output logic [7:0]               mem_wdata,
    output logic [mem_addr_bits-1:0] mem_raddr,
    input  wire  [7:0]               mem_rdata
);

    slave_state_e                     state;
    access_op_e                       op_q;
    access_op_e                       rx_op;
    logic [2:0]                       bit_cnt;
    logic [7:0]                       shift_reg;
    logic [7:0]                       rx_byte;
    logic [mem_addr_bits-9:0]         block_bits;
    logic [mem_addr_bits-1:0]         addr_cnt;
    logic                             rx_state;
    logic                             byte_done;
    logic                             load_tx;

    assign rx_byte   = {shift_reg[6:0], data_bit};
    assign rx_op     = access_op_e'(rx_byte[0]);
    assign rx_state  = (state == ctrl_rx) || (state == addr_rx) || (state == write_rx);
    assign byte_done = scl_rise && rx_state && (bus_cond == cond_none)
                       && (int'(bit_cnt) == byte_bits - 1);

    // The next read byte is taken at the fall that ends an acknowledge.
    assign load_tx = scl_fall && (bus_cond == cond_none)
                     && ((state == ctrl_ack && data_pull_low && op_q == op_read)
                         || state == read_ack);

    // Reads always come from the counter, so data waits in the array.
    assign mem_raddr = addr_cnt;

    //////////////////////////////
    // Control state
    //////////////////////////////

    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state         <= idle;
            op_q          <= op_write;
            bit_cnt       <= '0;
            block_bits    <= '0;
            addr_cnt      <= '0;
            data_pull_low <= 1'b0;
            mem_write     <= 1'b0;
        end
        else
        begin
            mem_write <= 1'b0;
            if (bus_cond == cond_start)
            begin
                state         <= ctrl_rx;
                bit_cnt       <= '0;
                data_pull_low <= 1'b0;
            end
            else if (bus_cond == cond_stop)
            begin
                state         <= idle;
                data_pull_low <= 1'b0;
            end
            else if (scl_rise)
            begin
                if (rx_state)
                    bit_cnt <= bit_cnt + 3'd1;
                if (byte_done)
                begin
                    case (state)
                        ctrl_rx:
                        begin
                            if (rx_byte[7:4] == device_code)
                            begin
                                state <= ctrl_ack;
                                op_q  <= rx_op;
                                if (rx_op == op_write)
                                    block_bits <= rx_byte[3:1];
                            end
                            else
                                state <= idle;
                        end
                        addr_rx:
                        begin
                            addr_cnt <= {block_bits, rx_byte};
                            state    <= addr_ack;
                        end
                        default:
                        begin
                            mem_write <= 1'b1;
                            addr_cnt  <= addr_cnt + mem_addr_bits'(1);
                            state     <= write_ack;
                        end
                    endcase
                end
                else if (state == read_ack && data_bit)
                    state <= idle;   // master NACK ends the read
            end
            else if (load_tx)
            begin
                state         <= read_tx;
                bit_cnt       <= '0;
                data_pull_low <= ~mem_rdata[7];
                addr_cnt      <= addr_cnt + mem_addr_bits'(1);
            end
            else if (scl_fall)
            begin
                case (state)
                    ctrl_ack, addr_ack, write_ack:
                    begin
                        // The first fall drives the acknowledge and the second releases it.
                        data_pull_low <= !data_pull_low;
                        if (data_pull_low)
                            state <= (state == ctrl_ack) ? addr_rx : write_rx;
                    end
                    read_tx:
                    begin
                        if (int'(bit_cnt) == byte_bits - 1)
                        begin
                            data_pull_low <= 1'b0;
                            bit_cnt       <= '0;
                            state         <= read_ack;
                        end
                        else
                        begin
                            data_pull_low <= ~shift_reg[7];
                            bit_cnt       <= bit_cnt + 3'd1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////
    // Shift register and write data
    //////////////////////////////

    always_ff @(posedge sda)
    begin
        if (scl_rise && rx_state)
            shift_reg <= rx_byte;
        else if (load_tx)
            shift_reg <= {mem_rdata[6:0], 1'b0};
        else if (scl_fall && state == read_tx)
            shift_reg <= {shift_reg[6:0], 1'b0};

        if (byte_done && state == write_rx)
        begin
            mem_waddr <= addr_cnt;
            mem_wdata <= rx_byte;
        end
    end

endmodule

`default_nettype wire

// File: source/eeprom_array.sv
`default_nettype none

module eeprom_array
    import eeprom_pkg::*;
(
    input  wire                      sda,
    input  wire                      mem_write,
    input  wire  [mem_addr_bits-1:0] mem_waddr,
    input  wire  [7:0]               mem_wdata,
    input  wire  [mem_addr_bits-1:0] mem_raddr,
    output logic [7:0]               mem_rdata
);

    logic [7:0] storage [mem_depth];

    // One write port and one registered read port.
    always_ff @(posedge sda)
    begin
        if (mem_write)
            storage[mem_waddr] <= mem_wdata;
        mem_rdata <= storage[mem_raddr];
    end

endmodule

`default_nettype wire

// File: source/eeprom_top.sv
`default_nettype none

module eeprom_top
    import i2c_bus_pkg::*;
    import eeprom_pkg::*;
(
    input  wire  sda,
    input  wire  rst_n,
    input  wire  bus_scl,
    input  wire  bus_data,
    output logic data_pull_low
);

    logic                     scl_rise;
    logic                     scl_fall;
    bus_cond_e                bus_cond;
    logic                     data_bit;
    logic                     mem_write;
    logic [mem_addr_bits-1:0] mem_waddr;
    logic [7:0]               mem_wdata;
    logic [mem_addr_bits-1:0] mem_raddr;
    logic [7:0]               mem_rdata;

    i2c_line_sync line_sync_i (
        .sda      (sda),
        .rst_n    (rst_n),
        .bus_scl  (bus_scl),
        .bus_data (bus_data),
        .scl_rise (scl_rise),
        .scl_fall (scl_fall),
        .bus_cond (bus_cond),
        .data_bit (data_bit)
    );

    eeprom_slave_fsm slave_fsm_i (
        .sda           (sda),
        .rst_n         (rst_n),
        .scl_rise      (scl_rise),
        .scl_fall      (scl_fall),
        .bus_cond      (bus_cond),
        .data_bit      (data_bit),
        .data_pull_low (data_pull_low),
        .mem_write     (mem_write),
        .mem_waddr     (mem_waddr),
        .mem_wdata     (mem_wdata),
        .mem_raddr     (mem_raddr),
        .mem_rdata     (mem_rdata)
    );

    eeprom_array array_i (
        .sda       (sda),
        .mem_write (mem_write),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .mem_raddr (mem_raddr),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// File: bench/clock_gen.sv
`default_nettype none

module clock_gen (
    output logic sda,
    output logic rst_n
);

    localparam int half_period  = 20;
    localparam int reset_cycles = 4;

    initial
    begin
        sda = 1'b0;
        forever
            #half_period sda = ~sda;
    end

    // Reset is released on a falling edge of the clock.
    initial
    begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge sda);
        @(negedge sda);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: bench/eeprom_tb.sv
`default_nettype none

module eeprom_tb
    import i2c_bus_pkg::*;
    import eeprom_pkg::*;
();

    localparam int half_period = 8;
    localparam int wait_limit  = 64;

    logic                     sda;
    logic                     rst_n;
    logic                     scl_drv;
    logic                     sda_drv;
    logic                     data_pull_low;
    logic                     bus_data;
    logic [7:0]               ref_mem [mem_depth];
    logic [7:0]               tx_data [8];
    logic [mem_addr_bits-1:0] cur_addr;
    logic [mem_addr_bits-1:0] first_addr;
    logic [mem_addr_bits-1:0] block5_addr;
    logic [31:0]              lfsr_state;
    string                    test_name;
    int                       test_errors;
    int                       error_count;
    int                       tests_run;
    int                       tests_passed;

    // Wired-AND data line.
    assign bus_data = sda_drv & ~data_pull_low;

    clock_gen clock_gen_i (
        .sda   (sda),
        .rst_n (rst_n)
    );

    eeprom_top dut_i (
        .sda           (sda),
        .rst_n         (rst_n),
        .bus_scl       (scl_drv),
        .bus_data      (bus_data),
        .data_pull_low (data_pull_low)
    );

    //////////////////////////////
    // Reporting and random data
    //////////////////////////////

    task automatic report_value(input string what, input logic [7:0] expected,
                                input logic [7:0] actual);
        $display("ERR %s: %s expected 0x%02h actual 0x%02h", test_name, what, expected, actual);
        test_errors++;
    endtask

    task automatic report_problem(input string what);
        $display("%s: %s", test_name, what);
        test_errors++;
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    //////////////////////////////
    // Bus master
    //////////////////////////////

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge sda);
    endtask

    task automatic wait_reset();
        int count;
        count = 0;
        while (rst_n !== 1'b1 && count < wait_limit)
        begin
            @(negedge sda);
            count++;
        end
        if (rst_n !== 1'b1)
            report_problem("timed out waiting for reset to be released");
        wait_cycles(half_period);
    endtask

    task automatic wait_line_high();
        int count;
        count = 0;
        while (bus_data !== 1'b1 && count < wait_limit)
        begin
            @(negedge sda);
            count++;
        end
        if (bus_data !== 1'b1)
            report_problem("timed out waiting for the slave to release the data line");
    endtask

    // Also serves as a repeated start when entered with the bus clock low.
    task automatic bus_start();
        sda_drv = 1'b1;
        wait_line_high();
        wait_cycles(half_period / 2);
        scl_drv = 1'b1;
        wait_cycles(half_period);
        sda_drv = 1'b0;
        wait_cycles(half_period);
        scl_drv = 1'b0;
        wait_cycles(half_period / 2);
    endtask

    task automatic bus_stop();
        sda_drv = 1'b0;
        wait_cycles(half_period / 2);
        scl_drv = 1'b1;
        wait_cycles(half_period);
        sda_drv = 1'b1;
        wait_cycles(half_period);
    endtask

    // Data changes mid low phase and the line is sampled at the end of the high phase.
    task automatic clock_bit(input logic value, output logic seen);
        sda_drv = value;
        wait_cycles(half_period / 2);
        scl_drv = 1'b1;
        wait_cycles(half_period);
        seen = bus_data;
        scl_drv = 1'b0;
        wait_cycles(half_period / 2);
    endtask

    task automatic send_byte(input logic [7:0] value, output logic ack);
        logic seen;
        for (int i = byte_bits - 1; i >= 0; i--)
            clock_bit(value[i], seen);
        clock_bit(1'b1, ack);
    endtask

    task automatic recv_byte(input logic nack, output logic [7:0] value);
        logic seen;
        value = '0;
        for (int i = 0; i < byte_bits; i++)
        begin
            clock_bit(1'b1, seen);
            value = {value[6:0], seen};
        end
        clock_bit(nack, seen);
    endtask

    task automatic send_checked(input logic [7:0] value, input string what);
        logic ack;
        send_byte(value, ack);
        if (ack !== 1'b0)
            report_value({"acknowledge of ", what}, 8'h00, {7'b0, ack});
    endtask

    //////////////////////////////
    // Transactions
    //////////////////////////////

    task automatic set_address(input logic [mem_addr_bits-1:0] addr);
        bus_start();
        send_checked({device_code, addr[mem_addr_bits-1:8], 1'b0}, "write control");
        send_checked(addr[7:0], "word address");
        cur_addr = addr;
    endtask

    task automatic write_bytes(input logic [mem_addr_bits-1:0] addr, input int n);
        set_address(addr);
        for (int i = 0; i < n; i++)
        begin
            send_checked(tx_data[i], "data byte");
            ref_mem[cur_addr] = tx_data[i];
            cur_addr = cur_addr + mem_addr_bits'(1);
        end
        bus_stop();
    endtask

    // Reads from the tracked address, with a NACK on the last byte.
    task automatic read_bytes(input int n);
        logic [7:0] value;
        logic       released;
        bus_start();
        send_checked({device_code, cur_addr[mem_addr_bits-1:8], 1'b1}, "read control");
        for (int i = 0; i < n; i++)
        begin
            recv_byte(i == n - 1, value);
            if (value !== ref_mem[cur_addr])
                report_value($sformatf("read at 0x%03h", cur_addr), ref_mem[cur_addr], value);
            cur_addr = cur_addr + mem_addr_bits'(1);
        end
        released = 1'b1;
        for (int i = 0; i < half_period; i++)
        begin
            if (data_pull_low !== 1'b0)
                released = 1'b0;
            @(negedge sda);
        end
        if (!released)
            report_problem("slave pulls the data line low after the master's NACK");
        bus_stop();
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        error_count += test_errors;
        if (test_errors == 0)
        begin
            tests_passed++;
            $display("test %s: PASS", test_name);
        end
        else
            $display("test %s: FAIL with %0d errors", test_name, test_errors);
    endtask

    task automatic byte_write_random_read();
        logic [31:0] r;
        begin_test("byte_write_random_read");
        take_bits(mem_addr_bits, r);
        first_addr = r[mem_addr_bits-1:0];
        take_bits(8, r);
        tx_data[0] = r[7:0];
        write_bytes(first_addr, 1);
        set_address(first_addr);
        read_bytes(1);
        end_test();
    endtask

    task automatic sequential_write_read();
        logic [31:0]              r;
        logic [mem_addr_bits-1:0] start;
        begin_test("sequential_write_read");
        // The block ends just below the byte of the first test.
        start = first_addr - mem_addr_bits'(4);
        for (int i = 0; i < 4; i++)
        begin
            take_bits(8, r);
            tx_data[i] = r[7:0];
        end
        write_bytes(start, 4);
        set_address(start);
        read_bytes(4);
        end_test();
    endtask

    task automatic current_address_read();
        begin_test("current_address_read");
        read_bytes(1);
        end_test();
    endtask

    task automatic block_select();
        logic [31:0]              r;
        logic [mem_addr_bits-1:0] block0_addr;
        begin_test("block_select");
        take_bits(8, r);
        block0_addr = {3'd0, r[7:0]};
        block5_addr = {3'd5, r[7:0]};
        take_bits(8, r);
        tx_data[0] = r[7:0];
        write_bytes(block0_addr, 1);
        tx_data[0] = ~r[7:0];
        write_bytes(block5_addr, 1);
        set_address(block0_addr);
        read_bytes(1);
        set_address(block5_addr);
        read_bytes(1);
        end_test();
    endtask

    task automatic wrong_device_code();
        logic ack;
        begin_test("wrong_device_code");
        bus_start();
        // Code 1011 differs from the slave's code in one bit.
        send_byte({device_code ^ 4'b0001, 3'b000, 1'b0}, ack);
        if (ack !== 1'b1)
            report_value("line level at the acknowledge bit", 8'h01, {7'b0, ack});
        bus_stop();
        set_address(first_addr);
        read_bytes(1);
        end_test();
    endtask

    task automatic stop_aborts_write();
        logic ack;
        begin_test("stop_aborts_write");
        set_address(block5_addr);
        bus_stop();
        // An idle slave ignores a byte that is clocked in without a start.
        scl_drv = 1'b0;
        wait_cycles(half_period / 2);
        send_byte(~ref_mem[block5_addr], ack);
        if (ack !== 1'b1)
            report_value("line level at the acknowledge bit", 8'h01, {7'b0, ack});
        set_address(block5_addr);
        read_bytes(1);
        end_test();
    endtask

    initial
    begin
        scl_drv = 1'b1;
        sda_drv = 1'b1;
        lfsr_state = 32'hd37b4983;
        cur_addr = '0;
        test_errors = 0;
        error_count = 0;
        tests_run = 0;
        tests_passed = 0;
        test_name = "reset";
        wait_reset();
        if (data_pull_low !== 1'b0)
            report_value("data_pull_low after reset", 8'h00, {7'b0, data_pull_low});
        error_count += test_errors;

        byte_write_random_read();
        sequential_write_read();
        current_address_read();
        block_select();
        wrong_device_code();
        stop_aborts_write();

        $display("tests run %0d, passed %0d, errors %0d", tests_run, tests_passed, error_count);
        if (error_count == 0 && tests_passed == tests_run)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
source/i2c_bus_pkg.sv
source/eeprom_pkg.sv
source/i2c_line_sync.sv
source/eeprom_slave_fsm.sv
source/eeprom_array.sv
source/eeprom_top.sv
bench/clock_gen.sv
bench/eeprom_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing -j 0
TOP      := eeprom_tb
FILELIST := sim.f
BUILD    := obj_dir
LOG      := sim.log
FAIL_MSG := Simulation failed
PASS_MSG := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Result: no pass line"; exit 1; fi
	@echo "Result: PASS"

clean:
	rm -rf $(BUILD) $(LOG)
